// ==== hdl/fe_pkg.sv ====
`default_nettype none

package fe_pkg;

    localparam int XLEN       = 32;
    localparam int IMEM_AW    = 8;
    localparam int IMEM_DEPTH = 1 << IMEM_AW;

    localparam logic [XLEN-1:0] PC_START = '0;
    localparam logic [XLEN-1:0] PC_STEP  = 32'd4;
    // addi x0, x0, 0
    localparam logic [XLEN-1:0] INST_NOP = 32'h0000_0013;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t          r_fmt;
        i_fmt_t          i_fmt;
        s_fmt_t          s_fmt;
        b_fmt_t          b_fmt;
        j_fmt_t          j_fmt;
        logic [XLEN-1:0] raw;
    } inst_u;

    typedef struct packed {
        logic               we;
        logic [IMEM_AW-1:0] addr;
        logic [XLEN-1:0]    wdata;
    } mem_req_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
    } fetch_rsp_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        opcode_e         opcode;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [2:0]      funct3;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] raw;
    } id_out_t;

endpackage

`default_nettype wire

// ==== hdl/imem.sv ====
`timescale 1ns/1ps
`default_nettype none

module imem (
    input  wire                   clk,
    input  wire fe_pkg::mem_req_t req_i,
    input  wire                   re_i,
    output logic [31:0]           rdata_o
);
    import fe_pkg::*;

    logic [XLEN-1:0] mem [IMEM_DEPTH];

    always_ff @(posedge clk) begin
        if (req_i.we) begin
            mem[req_i.addr] <= req_i.wdata;
        end
    end

    // One cycle read latency
    always_ff @(posedge clk) begin
        if (re_i) begin
            rdata_o <= mem[req_i.addr];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/imem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module imem_arbiter (
    input  wire                          clk,
    input  wire                          arst_n_i,
    input  wire                          load_we_i,
    input  wire [fe_pkg::IMEM_AW-1:0]    load_addr_i,
    input  wire [fe_pkg::XLEN-1:0]       load_data_i,
    input  wire                          fetch_re_i,
    input  wire [fe_pkg::XLEN-1:0]       fetch_pc_i,
    output fe_pkg::mem_req_t             mem_req_o,
    output logic                         mem_re_o,
    input  wire [fe_pkg::XLEN-1:0]       mem_rdata_i,
    output fe_pkg::fetch_rsp_t           rsp_o
);
    import fe_pkg::*;

    logic            grant;
    logic            grant_q;
    logic [XLEN-1:0] pc_q;

    // Loader always wins the port
    assign grant    = fetch_re_i && !load_we_i;
    assign mem_re_o = grant;

    always_comb begin
        mem_req_o.we    = load_we_i;
        mem_req_o.addr  = load_we_i ? load_addr_i : fetch_pc_i[IMEM_AW+1:2];
        mem_req_o.wdata = load_data_i;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            grant_q <= 1'b0;
        end else begin
            grant_q <= grant;
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            pc_q <= fetch_pc_i;
        end
    end

    // Pair read data with the address it was fetched from
    assign rsp_o = '{valid: grant_q, pc: pc_q, inst: mem_rdata_i};

endmodule

`default_nettype wire

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  wire                     clk,
    input  wire                     arst_n_i,
    input  wire                     run_i,
    input  wire                     stall_i,
    input  wire                     redirect_i,
    input  wire [fe_pkg::XLEN-1:0]  redirect_pc_i,
    input  wire fe_pkg::fetch_rsp_t rsp_i,
    output logic                    fetch_re_o,
    output logic [fe_pkg::XLEN-1:0] fetch_pc_o,
    output fe_pkg::fetch_rsp_t      rsp_o
);
    import fe_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic            pend_q;
    logic [XLEN-1:0] pend_pc_q;
    logic            kill_q;
    logic            replay;
    logic [XLEN-1:0] issue_pc;

    // Last read was refused by the arbiter or could not enter IF/ID
    assign replay   = pend_q && !kill_q && (!rsp_i.valid || stall_i);
    assign issue_pc = replay ? pend_pc_q : pc_q;

    assign fetch_re_o = run_i;
    assign fetch_pc_o = issue_pc;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q   <= PC_START;
            pend_q <= 1'b0;
            kill_q <= 1'b0;
        end else begin
            pend_q <= run_i;
            kill_q <= redirect_i;
            if (redirect_i) begin
                pc_q <= redirect_pc_i;
            end else if (run_i) begin
                pc_q <= issue_pc + PC_STEP;
            end else begin
                // Keep a pending replay address while idle
                pc_q <= issue_pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        pend_pc_q <= issue_pc;
    end

    // Read issued in the redirect cycle is on the wrong path
    always_comb begin
        rsp_o       = rsp_i;
        rsp_o.valid = rsp_i.valid && !kill_q;
    end

endmodule

`default_nettype wire

// ==== hdl/if2id_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module if2id_reg (
    input  wire                     clk,
    input  wire                     arst_n_i,
    input  wire                     flush_i,
    input  wire                     stall_i,
    input  wire fe_pkg::fetch_rsp_t rsp_i,
    output logic                    nop_o,
    output fe_pkg::fetch_rsp_t      word_o
);
    import fe_pkg::*;

    logic            nop_q;
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] inst_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            nop_q  <= 1'b1;
            pc_q   <= PC_START;
            inst_q <= INST_NOP;
        end else if (flush_i) begin
            nop_q  <= 1'b1;
            pc_q   <= PC_START;
            inst_q <= INST_NOP;
        end else if (stall_i) begin
            nop_q  <= nop_q;
            pc_q   <= pc_q;
            inst_q <= inst_q;
        end else if (rsp_i.valid) begin
            nop_q  <= 1'b0;
            pc_q   <= rsp_i.pc;
            inst_q <= rsp_i.inst;
        end else begin
            // Word was consumed and nothing arrived, so emit a bubble
            nop_q  <= 1'b1;
            pc_q   <= pc_q;
            inst_q <= inst_q;
        end
    end

    assign nop_o  = nop_q;
    assign word_o = '{valid: !nop_q, pc: pc_q, inst: inst_q};

endmodule

`default_nettype wire

// ==== hdl/id_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_decode (
    input  wire fe_pkg::fetch_rsp_t word_i,
    input  wire                     nop_i,
    input  wire                     stall_i,
    output fe_pkg::id_out_t         id_o,
    output logic                    redirect_o,
    output logic [fe_pkg::XLEN-1:0] redirect_pc_o
);
    import fe_pkg::*;

    inst_u           inst;
    opcode_e         opcode;
    logic            valid;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm;
    logic            has_rd;
    logic            has_rs1;
    logic            has_rs2;
    logic            has_f3;

    assign inst   = word_i.inst;
    assign opcode = opcode_e'(inst.r_fmt.opcode);
    assign valid  = !nop_i && !stall_i;

    assign imm_i = {{(XLEN-12){inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};
    assign imm_s = {{(XLEN-12){inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
    assign imm_b = {{(XLEN-13){inst.b_fmt.imm_12}}, inst.b_fmt.imm_12, inst.b_fmt.imm_11,
                    inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
    assign imm_j = {{(XLEN-21){inst.j_fmt.imm_20}}, inst.j_fmt.imm_20, inst.j_fmt.imm_19_12,
                    inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};
    assign imm_u = {inst.raw[XLEN-1:12], 12'b0};

    // Fields absent from a format read as zero
    always_comb begin
        imm     = '0;
        has_rd  = 1'b0;
        has_rs1 = 1'b0;
        has_rs2 = 1'b0;
        has_f3  = 1'b0;
        case (opcode)
            OP: begin
                {has_rd, has_rs1, has_rs2, has_f3} = 4'b1111;
            end
            OP_IMM, LOAD, JALR: begin
                imm = imm_i;
                {has_rd, has_rs1, has_rs2, has_f3} = 4'b1101;
            end
            STORE: begin
                imm = imm_s;
                {has_rd, has_rs1, has_rs2, has_f3} = 4'b0111;
            end
            BRANCH: begin
                imm = imm_b;
                {has_rd, has_rs1, has_rs2, has_f3} = 4'b0111;
            end
            JAL: begin
                imm    = imm_j;
                has_rd = 1'b1;
            end
            LUI, AUIPC: begin
                imm    = imm_u;
                has_rd = 1'b1;
            end
            default: begin
                imm = '0;
            end
        endcase
    end

    always_comb begin
        id_o.valid  = valid;
        id_o.pc     = word_i.pc;
        id_o.opcode = opcode;
        id_o.rd     = has_rd ? inst.r_fmt.rd : 5'd0;
        id_o.rs1    = has_rs1 ? inst.r_fmt.rs1 : 5'd0;
        id_o.rs2    = has_rs2 ? inst.r_fmt.rs2 : 5'd0;
        id_o.funct3 = has_f3 ? inst.r_fmt.funct3 : 3'd0;
        id_o.imm    = imm;
        id_o.raw    = inst.raw;
    end

    assign redirect_o    = valid && (opcode == JAL);
    assign redirect_pc_o = word_i.pc + imm_j;

endmodule

`default_nettype wire

// ==== hdl/frontend_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module frontend_top (
    input  wire                       clk,
    input  wire                       arst_n_i,
    input  wire                       run_i,
    input  wire                       stall_i,
    input  wire                       load_we_i,
    input  wire [fe_pkg::IMEM_AW-1:0] load_addr_i,
    input  wire [fe_pkg::XLEN-1:0]    load_data_i,
    output fe_pkg::id_out_t           id_o
);
    import fe_pkg::*;

    mem_req_t        mem_req;
    logic            mem_re;
    logic [XLEN-1:0] mem_rdata;
    logic            fetch_re;
    logic [XLEN-1:0] fetch_pc;
    fetch_rsp_t      arb_rsp;
    fetch_rsp_t      fet_rsp;
    fetch_rsp_t      if_word;
    logic            if_nop;
    logic            redirect;
    logic [XLEN-1:0] redirect_pc;

    imem i_imem (
        .clk     (clk),
        .req_i   (mem_req),
        .re_i    (mem_re),
        .rdata_o (mem_rdata)
    );

    imem_arbiter i_imem_arbiter (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .load_we_i   (load_we_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i),
        .fetch_re_i  (fetch_re),
        .fetch_pc_i  (fetch_pc),
        .mem_req_o   (mem_req),
        .mem_re_o    (mem_re),
        .mem_rdata_i (mem_rdata),
        .rsp_o       (arb_rsp)
    );

    fetch_unit i_fetch_unit (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .run_i         (run_i),
        .stall_i       (stall_i),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .rsp_i         (arb_rsp),
        .fetch_re_o    (fetch_re),
        .fetch_pc_o    (fetch_pc),
        .rsp_o         (fet_rsp)
    );

    // Redirect doubles as the IF/ID flush
    if2id_reg i_if2id_reg (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .flush_i  (redirect),
        .stall_i  (stall_i),
        .rsp_i    (fet_rsp),
        .nop_o    (if_nop),
        .word_o   (if_word)
    );

    id_decode i_id_decode (
        .word_i        (if_word),
        .nop_i         (if_nop),
        .stall_i       (stall_i),
        .id_o          (id_o),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc)
    );

endmodule

`default_nettype wire

// ==== testbench/frontend_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module frontend_tb;
    import fe_pkg::*;

    localparam int PROG_LEN  = 30;
    localparam int LOAD_BASE = 64;
    localparam int LOAD_LEN  = 6;
    localparam int TIMEOUT   = 400;

    logic               clk;
    logic               arst_n_i;
    logic               run_i;
    logic               stall_i;
    logic               load_we_i;
    logic [IMEM_AW-1:0] load_addr_i;
    logic [XLEN-1:0]    load_data_i;
    id_out_t            id_o;

    logic [XLEN-1:0] mirror [IMEM_DEPTH];
    logic [XLEN-1:0] exp_pc;
    int  cycle;
    int  run_cycle;
    int  first_cycle;
    int  jal_cycle;
    int  jal_checks;
    int  loaded_seen;
    int  words_seen;
    bit  run_seen;
    bit  jal_pending;
    bit  clean;
    int  err_idle;
    int  err_order;
    int  err_decode;
    int  err_jal;
    int  err_stall;
    int  n_pass;
    int  n_fail;

    frontend_top i_frontend_top (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .run_i       (run_i),
        .stall_i     (stall_i),
        .load_we_i   (load_we_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i),
        .id_o        (id_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Decode of a stored word following the RV32I field layouts
    function automatic id_out_t model_decode(input logic [XLEN-1:0] pc,
                                             input logic [XLEN-1:0] w);
        id_out_t d;
        logic [6:0] op;
        op       = w[6:0];
        d        = '0;
        d.valid  = 1'b1;
        d.pc     = pc;
        d.raw    = w;
        d.opcode = opcode_e'(op);
        case (op)
            7'b0110011: begin
                d.rd = w[11:7];
                d.rs1 = w[19:15];
                d.rs2 = w[24:20];
                d.funct3 = w[14:12];
            end
            7'b0010011, 7'b0000011, 7'b1100111: begin
                d.rd = w[11:7];
                d.rs1 = w[19:15];
                d.funct3 = w[14:12];
                d.imm = {{20{w[31]}}, w[31:20]};
            end
            7'b0100011: begin
                d.rs1 = w[19:15];
                d.rs2 = w[24:20];
                d.funct3 = w[14:12];
                d.imm = {{20{w[31]}}, w[31:25], w[11:7]};
            end
            7'b1100011: begin
                d.rs1 = w[19:15];
                d.rs2 = w[24:20];
                d.funct3 = w[14:12];
                d.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
            7'b1101111: begin
                d.rd = w[11:7];
                d.imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            7'b0110111, 7'b0010111: begin
                d.rd = w[11:7];
                d.imm = {w[31:12], 12'b0};
            end
            default: d.imm = '0;
        endcase
        return d;
    endfunction

    function automatic logic [XLEN-1:0] rand_inst(input int k);
        logic [XLEN-1:0] r;
        r = $urandom;
        case (k % 5)
            0: return {r[31:7], 7'b0110011};
            1: return {r[31:7], 7'b0010011};
            2: return {r[31:7], 7'b0000011};
            3: return {r[31:7], 7'b0100011};
            default: return {r[31:7], 7'b0110111};
        endcase
    endfunction

    function automatic logic [XLEN-1:0] jal_word(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // Reference model follows the program from its own pc and samples at the falling edge
    always @(negedge clk) begin : check
        id_out_t ref_d;
        if (arst_n_i) begin
            if (run_i) run_seen = 1'b1;
            if (stall_i || load_we_i) clean = 1'b0;
            assert (!id_o.valid || run_seen) else begin
                err_idle++;
                $display("** Error: reset_idle: expected valid 0, actual 1 (pc %h)", id_o.pc);
            end
            assert (!(stall_i && id_o.valid)) else begin
                err_stall++;
                $display("** Error: random_stall: expected valid 0, actual 1 (pc %h)",
                         id_o.pc);
            end
            if (id_o.valid) begin
                ref_d = model_decode(exp_pc, mirror[exp_pc[IMEM_AW+1:2]]);
                words_seen++;
                if (first_cycle < 0) first_cycle = cycle;
                if (id_o.pc >= LOAD_BASE * 4) loaded_seen++;
                if (jal_pending) begin
                    assert (id_o.pc == exp_pc) else begin
                        err_jal++;
                        $display("** Error: jal_redirect: expected pc %h, actual %h",
                                 exp_pc, id_o.pc);
                    end
                    if (clean) begin
                        jal_checks++;
                        assert (cycle == jal_cycle + 3) else begin
                            err_jal++;
                            $display("** Error: jal_redirect latency: expected %0d, actual %0d",
                                     3, cycle - jal_cycle);
                        end
                    end
                    jal_pending = 1'b0;
                end else begin
                    assert (id_o.pc == exp_pc) else begin
                        err_order++;
                        $display("** Error: order: expected pc %h, actual %h", exp_pc, id_o.pc);
                    end
                end
                assert (id_o.raw == ref_d.raw) else begin
                    err_order++;
                    $display("** Error: raw: expected %h, actual %h", ref_d.raw, id_o.raw);
                end
                assert ({id_o.opcode, id_o.rd, id_o.rs1, id_o.rs2, id_o.funct3, id_o.imm} ==
                        {ref_d.opcode, ref_d.rd, ref_d.rs1, ref_d.rs2, ref_d.funct3, ref_d.imm})
                else begin
                    err_decode++;
                    $display("** Error: decode_fields at %h: expected %h, actual %h", exp_pc,
                             {ref_d.opcode, ref_d.rd, ref_d.rs1, ref_d.rs2, ref_d.funct3,
                              ref_d.imm},
                             {id_o.opcode, id_o.rd, id_o.rs1, id_o.rs2, id_o.funct3,
                              id_o.imm});
                end
                if (ref_d.opcode == JAL) begin
                    jal_pending = 1'b1;
                    jal_cycle   = cycle;
                    clean       = 1'b1;
                    exp_pc      = exp_pc + ref_d.imm;
                end else begin
                    exp_pc = exp_pc + 32'd4;
                end
            end
        end
    end

    task automatic step();
        @(posedge clk);
        #10;
    endtask

    task automatic load_word(input int addr, input logic [XLEN-1:0] data);
        step();
        load_we_i   = 1'b1;
        load_addr_i = IMEM_AW'(addr);
        load_data_i = data;
        mirror[addr] = data;
        step();
        load_we_i = 1'b0;
    endtask

    task automatic report_test(input string name, input int errs);
        if (errs == 0) begin
            n_pass++;
            $display("PASS  %s", name);
        end else begin
            n_fail++;
            $display("** Error: %s: expected 0 failed checks, actual %0d", name, errs);
        end
    endtask

    task automatic idle_after_reset();
        for (int k = 0; k < PROG_LEN; k++) begin
            load_word(k, rand_inst(k));
        end
        load_word(PROG_LEN, jal_word(21'd136, 5'd1));
        repeat (4) step();
        report_test("reset_idle", err_idle);
    endtask

    task automatic first_fetch_latency();
        int t;
        int errs;
        int before_order;
        errs         = 0;
        before_order = err_order;
        step();
        run_i     = 1'b1;
        run_cycle = cycle;
        for (t = 0; t < TIMEOUT && first_cycle < 0; t++) @(posedge clk);
        if (first_cycle < 0) begin
            $display("Timeout: no valid word left decode after run was raised");
            errs++;
        end else begin
            assert (first_cycle == run_cycle + 2) else begin
                errs++;
                $display("** Error: first_fetch latency: expected %0d, actual %0d",
                         2, first_cycle - run_cycle);
            end
        end
        repeat (8) step();
        report_test("first_fetch", errs + err_order - before_order);
    endtask

    task automatic load_while_running();
        int t;
        int errs;
        int before_order;
        errs         = 0;
        before_order = err_order;
        for (int k = 0; k < LOAD_LEN - 1; k++) begin
            repeat ($urandom_range(0, 2)) step();
            load_word(LOAD_BASE + k, rand_inst(k));
        end
        load_word(LOAD_BASE + LOAD_LEN - 1, jal_word(21'h1F_FFF4, 5'd0));
        for (t = 0; t < TIMEOUT && loaded_seen < LOAD_LEN; t++) @(posedge clk);
        if (loaded_seen < LOAD_LEN) begin
            $display("Timeout: the words written while running were never fetched");
            errs++;
        end
        report_test("load_running", errs + err_order - before_order);
    endtask

    task automatic jal_redirect();
        int t;
        int errs;
        errs = 0;
        for (t = 0; t < TIMEOUT && jal_checks < 2; t++) @(posedge clk);
        if (jal_checks < 2) begin
            $display("Timeout: fewer than two undisturbed jumps were seen");
            errs++;
        end
        report_test("jal_redirect", errs + err_jal);
    endtask

    task automatic random_stall();
        int before_order;
        int before_words;
        int errs;
        before_order = err_order;
        before_words = words_seen;
        for (int k = 0; k < 80; k++) begin
            step();
            stall_i = ($urandom % 3 == 0);
        end
        step();
        stall_i = 1'b0;
        repeat (4) step();
        errs = err_stall + err_order - before_order;
        if (words_seen == before_words) begin
            $display("No word left decode during the random stall phase");
            errs++;
        end
        report_test("random_stall", errs);
    endtask

    task automatic decode_fields();
        int errs;
        errs = err_decode;
        if (words_seen == 0) begin
            $display("No decoded word was ever checked");
            errs++;
        end
        report_test("decode_fields", errs);
    endtask

    initial begin
        void'($urandom(43510));
        arst_n_i    = 1'b0;
        run_i       = 1'b0;
        stall_i     = 1'b0;
        load_we_i   = 1'b0;
        load_addr_i = '0;
        load_data_i = '0;
        cycle       = 0;
        first_cycle = -1;
        exp_pc      = PC_START;
        for (int a = 0; a < IMEM_DEPTH; a++) begin
            mirror[a] = {a[7:0], ~a[7:0], a[7:0] ^ 8'h5a, 8'h13};
        end
        repeat (3) @(posedge clk);
        #10;
        arst_n_i = 1'b1;

        idle_after_reset();
        first_fetch_latency();
        load_while_running();
        jal_redirect();
        random_stall();
        decode_fields();

        $display("Tests: %0d passed, %0d failed; errors %0d", n_pass, n_fail,
                 err_idle + err_order + err_decode + err_jal + err_stall);
        if (n_fail == 0 && err_idle + err_order + err_decode + err_jal + err_stall == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
hdl/fe_pkg.sv
hdl/imem.sv
hdl/imem_arbiter.sv
hdl/fetch_unit.sv
hdl/if2id_reg.sv
hdl/id_decode.sv
hdl/frontend_top.sv
testbench/frontend_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := frontend_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
